// File: bru_top.f
+incdir+include
hdl/bru_pkg.sv
hdl/bru_decoder.sv
hdl/bru_regfile.sv
hdl/bru_fwd_select.sv
hdl/bru_pipe.sv
hdl/bru_top.sv
verification/bru_tb.sv

// File: hdl/bru_decoder.sv
`default_nettype none

module bru_decoder
  import bru_pkg::*;
(
  input  logic [31:0] i_inst,
  output bru_ctrl_t   o_ctrl
);

  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  logic [6:0] w_opcode;
  logic [2:0] w_funct3;

  assign w_opcode = i_inst[6:0];
  assign w_funct3 = i_inst[14:12];

  always_comb begin
    o_ctrl.op    = OP_NONE;
    o_ctrl.imm   = IMM_NONE;
    o_ctrl.wr_rd = 1'b0;
    case (w_opcode)
      OPC_BRANCH: begin
        o_ctrl.imm = IMM_SB;
        case (w_funct3)
          3'b000:  o_ctrl.op = OP_EQ;
          3'b001:  o_ctrl.op = OP_NE;
          3'b100:  o_ctrl.op = OP_LT;
          3'b101:  o_ctrl.op = OP_GE;
          3'b110:  o_ctrl.op = OP_LTU;
          3'b111:  o_ctrl.op = OP_GEU;
          default: o_ctrl.imm = IMM_NONE;  // funct3 010 and 011 are reserved
        endcase
      end
      OPC_JAL: begin
        o_ctrl.op    = OP_JUMP;
        o_ctrl.imm   = IMM_UJ;
        o_ctrl.wr_rd = 1'b1;
      end
      OPC_JALR: begin
        if (w_funct3 == 3'b000) begin
          o_ctrl.op    = OP_JUMP;
          o_ctrl.imm   = IMM_I;
          o_ctrl.wr_rd = 1'b1;
        end
      end
      default: begin
        o_ctrl.op = OP_NONE;  // not a control transfer
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/bru_fwd_select.sv
`default_nettype none

`include "bru_params.svh"

module bru_fwd_select
  import bru_pkg::*;
#(
  parameter int BUS_NUM = `BRU_TGT_BUS
)
(
  input  logic [`BRU_PREG_W-1:0] i_src_tag,
  input  logic                   i_src_valid,
  input  bru_wr_t                i_bus [BUS_NUM],
  input  logic [`BRU_XLEN-1:0]   i_reg_data,
  output logic [`BRU_XLEN-1:0]   o_data,
  output logic                   o_hit
);

  logic [BUS_NUM-1:0]   w_match;
  logic [`BRU_XLEN-1:0] w_bus_data;
  logic                 w_src_live;

  assign w_src_live = i_src_valid & (i_src_tag != '0);  // x0 never forwards

  generate
    for (genvar b = 0; b < BUS_NUM; b++) begin : g_match
      assign w_match[b] = w_src_live & i_bus[b].valid & (i_bus[b].tag == i_src_tag);
    end
  endgenerate

  // the match vector is one-hot, so an or of the masked beats picks the data
  always_comb begin
    w_bus_data = '0;
    for (int b = 0; b < BUS_NUM; b++) begin
      w_bus_data = w_bus_data | ({`BRU_XLEN{w_match[b]}} & i_bus[b].data);
    end
  end

  assign o_hit  = |w_match;
  assign o_data = o_hit ? w_bus_data : i_reg_data;

endmodule

`default_nettype wire

// File: hdl/bru_pipe.sv
`default_nettype none

`include "bru_params.svh"

module bru_pipe
  import bru_pkg::*;
#(
  parameter int RV_ENTRY = `BRU_RV_ENTRY
)
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,

  input  bru_issue_t             i_issue,
  input  logic [RV_ENTRY-1:0]    i_index,

  output logic [31:0]            o_ctrl_inst,
  input  bru_ctrl_t              i_ctrl,

  output logic [`BRU_PREG_W-1:0] o_rd_tag  [2],
  input  logic [`BRU_XLEN-1:0]   i_rd_data [2],

  input  bru_wr_t                i_res_bus [`BRU_TGT_BUS],

  output bru_early_wr_t          o_early_wr,
  output bru_wr_t                o_wb,
  output bru_upd_t               o_br_upd,
  output bru_done_t              o_done
);

  bru_issue_t           r_ex1_issue;
  logic [RV_ENTRY-1:0]  r_ex1_index;
  bru_ctrl_t            r_ex1_ctrl;

  bru_issue_t           r_ex2_issue;
  logic [RV_ENTRY-1:0]  r_ex2_index;
  bru_ctrl_t            r_ex2_ctrl;
  logic [`BRU_XLEN-1:0] r_ex2_rs1_data;
  logic [`BRU_XLEN-1:0] r_ex2_rs2_data;

  logic [31:0]          w_ex2_inst;
  logic [`BRU_XLEN-1:0] w_ex2_rs1;
  logic [`BRU_XLEN-1:0] w_ex2_rs2;
  logic                 w_ex2_rs1_fwd;
  logic                 w_ex2_rs2_fwd;
  logic                 w_ex2_rs1_pred_hit;
  logic                 w_ex2_rs2_pred_hit;
  logic [`BRU_XLEN-1:0] w_ex2_off_sb;
  logic [`BRU_XLEN-1:0] w_ex2_off_uj;
  logic [`BRU_XLEN-1:0] w_ex2_off_i;
  logic [`BRU_XLEN-1:0] w_ex2_target;
  logic                 w_ex2_result;

  bru_issue_t           r_ex3_issue;
  logic [RV_ENTRY-1:0]  r_ex3_index;
  bru_ctrl_t            r_ex3_ctrl;
  logic                 r_ex3_result;
  logic [`BRU_XLEN-1:0] r_ex3_target;
  logic                 r_ex3_pred_hit;

  assign o_ctrl_inst = i_issue.inst;  // decoded in ex0

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
      r_ex1_index <= '0;
      r_ex1_ctrl  <= '0;
    end else begin
      r_ex1_issue <= i_issue;
      r_ex1_index <= i_index;
      r_ex1_ctrl  <= i_ctrl;
    end
  end

  assign o_early_wr.valid = r_ex1_issue.valid & r_ex1_issue.rd_valid;
  assign o_early_wr.tag   = r_ex1_issue.rd_tag;

  // an unused source reads x0
  assign o_rd_tag[0] = r_ex1_issue.rs1_valid ? r_ex1_issue.rs1_tag : '0;
  assign o_rd_tag[1] = r_ex1_issue.rs2_valid ? r_ex1_issue.rs2_tag : '0;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex2_issue    <= '0;
      r_ex2_index    <= '0;
      r_ex2_ctrl     <= '0;
      r_ex2_rs1_data <= '0;
      r_ex2_rs2_data <= '0;
    end else begin
      r_ex2_issue    <= r_ex1_issue;
      r_ex2_index    <= r_ex1_index;
      r_ex2_ctrl     <= r_ex1_ctrl;
      r_ex2_rs1_data <= i_rd_data[0];
      r_ex2_rs2_data <= i_rd_data[1];
    end
  end

  bru_fwd_select #(
    .BUS_NUM(`BRU_TGT_BUS)
  ) u_rs1_fwd (
    .i_src_tag  (r_ex2_issue.rs1_tag),
    .i_src_valid(r_ex2_issue.rs1_valid),
    .i_bus      (i_res_bus),
    .i_reg_data (r_ex2_rs1_data),
    .o_data     (w_ex2_rs1),
    .o_hit      (w_ex2_rs1_fwd)
  );

  bru_fwd_select #(
    .BUS_NUM(`BRU_TGT_BUS)
  ) u_rs2_fwd (
    .i_src_tag  (r_ex2_issue.rs2_tag),
    .i_src_valid(r_ex2_issue.rs2_valid),
    .i_bus      (i_res_bus),
    .i_reg_data (r_ex2_rs2_data),
    .o_data     (w_ex2_rs2),
    .o_hit      (w_ex2_rs2_fwd)
  );

  // a source that was promised for ex2 must arrive on a bus in ex2
  assign w_ex2_rs1_pred_hit = r_ex2_issue.rs1_pred_ready ? w_ex2_rs1_fwd : 1'b1;
  assign w_ex2_rs2_pred_hit = r_ex2_issue.rs2_pred_ready ? w_ex2_rs2_fwd : 1'b1;

  assign w_ex2_inst   = r_ex2_issue.inst;
  assign w_ex2_off_sb = {{(`BRU_XLEN-13){w_ex2_inst[31]}}, w_ex2_inst[31], w_ex2_inst[7],
                         w_ex2_inst[30:25], w_ex2_inst[11:8], 1'b0};
  assign w_ex2_off_uj = {{(`BRU_XLEN-21){w_ex2_inst[31]}}, w_ex2_inst[31],
                         w_ex2_inst[19:12], w_ex2_inst[20], w_ex2_inst[30:21], 1'b0};
  assign w_ex2_off_i  = {{(`BRU_XLEN-12){w_ex2_inst[31]}}, w_ex2_inst[31:20]};

  always_comb begin
    case (r_ex2_ctrl.imm)
      IMM_SB:  w_ex2_target = r_ex2_issue.pc + w_ex2_off_sb;
      IMM_UJ:  w_ex2_target = r_ex2_issue.pc + w_ex2_off_uj;
      IMM_I:   w_ex2_target = w_ex2_rs1 + w_ex2_off_i;  // jalr base is rs1
      default: w_ex2_target = '0;
    endcase
  end

  always_comb begin
    case (r_ex2_ctrl.op)
      OP_EQ:   w_ex2_result = (w_ex2_rs1 == w_ex2_rs2);
      OP_NE:   w_ex2_result = (w_ex2_rs1 != w_ex2_rs2);
      OP_LT:   w_ex2_result = ($signed(w_ex2_rs1) < $signed(w_ex2_rs2));
      OP_GE:   w_ex2_result = ($signed(w_ex2_rs1) >= $signed(w_ex2_rs2));
      OP_LTU:  w_ex2_result = (w_ex2_rs1 < w_ex2_rs2);
      OP_GEU:  w_ex2_result = (w_ex2_rs1 >= w_ex2_rs2);
      OP_JUMP: w_ex2_result = 1'b1;
      default: w_ex2_result = 1'b0;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex3_issue    <= '0;
      r_ex3_index    <= '0;
      r_ex3_ctrl     <= '0;
      r_ex3_result   <= 1'b0;
      r_ex3_target   <= '0;
      r_ex3_pred_hit <= 1'b0;
    end else begin
      r_ex3_issue    <= r_ex2_issue;
      r_ex3_index    <= r_ex2_index;
      r_ex3_ctrl     <= r_ex2_ctrl;
      r_ex3_result   <= w_ex2_result;
      r_ex3_target   <= w_ex2_target;
      r_ex3_pred_hit <= w_ex2_rs1_pred_hit & w_ex2_rs2_pred_hit;
    end
  end

  assign o_done.valid  = r_ex3_issue.valid;
  assign o_done.replay = ~r_ex3_pred_hit;  // scheduler reissues the entry
  assign o_done.index  = r_ex3_index;
  assign o_done.cmt_id = r_ex3_issue.cmt_id;

  assign o_br_upd.valid  = r_ex3_issue.valid & r_ex3_result & r_ex3_pred_hit;
  assign o_br_upd.target = r_ex3_target;
  assign o_br_upd.cmt_id = r_ex3_issue.cmt_id;

  assign o_wb.valid = r_ex3_issue.valid & r_ex3_ctrl.wr_rd & r_ex3_pred_hit;
  assign o_wb.tag   = r_ex3_issue.rd_tag;
  assign o_wb.data  = r_ex3_issue.pc + `BRU_XLEN'd4;

endmodule

`default_nettype wire

// File: hdl/bru_pkg.sv
`default_nettype none

`include "bru_params.svh"

package bru_pkg;

  typedef enum logic [2:0] {
    OP_EQ,
    OP_NE,
    OP_LT,
    OP_GE,
    OP_LTU,
    OP_GEU,
    OP_JUMP,
    OP_NONE
  } bru_op_t;

  typedef enum logic [1:0] {
    IMM_SB,
    IMM_UJ,
    IMM_I,
    IMM_NONE
  } bru_imm_t;

  typedef struct packed {
    bru_op_t  op;
    bru_imm_t imm;
    logic     wr_rd;  // jal and jalr write pc + 4 back
  } bru_ctrl_t;

  typedef struct packed {
    logic                   valid;
    logic [`BRU_XLEN-1:0]   pc;
    logic [31:0]            inst;
    logic [`BRU_PREG_W-1:0] rs1_tag;
    logic                   rs1_valid;
    logic                   rs1_pred_ready;  // scheduler expects rs1 on a bus in ex2
    logic [`BRU_PREG_W-1:0] rs2_tag;
    logic                   rs2_valid;
    logic                   rs2_pred_ready;
    logic [`BRU_PREG_W-1:0] rd_tag;
    logic                   rd_valid;
    logic [7:0]             cmt_id;
  } bru_issue_t;

  typedef struct packed {
    logic                   valid;
    logic [`BRU_PREG_W-1:0] tag;
    logic [`BRU_XLEN-1:0]   data;
  } bru_wr_t;

  typedef struct packed {
    logic                   valid;
    logic [`BRU_PREG_W-1:0] tag;
  } bru_early_wr_t;

  typedef struct packed {
    logic                 valid;
    logic [`BRU_XLEN-1:0] target;
    logic [7:0]           cmt_id;
  } bru_upd_t;

  typedef struct packed {
    logic                     valid;
    logic                     replay;
    logic [`BRU_RV_ENTRY-1:0] index;
    logic [7:0]               cmt_id;
  } bru_done_t;

endpackage

`default_nettype wire

// File: hdl/bru_regfile.sv
`default_nettype none

`include "bru_params.svh"

module bru_regfile
  import bru_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,

  input  logic [`BRU_PREG_W-1:0] i_rd_tag  [2],
  output logic [`BRU_XLEN-1:0]   o_rd_data [2],

  input  bru_wr_t                i_wr      [`BRU_TGT_BUS+1]
);

  localparam int WR_NUM = `BRU_TGT_BUS + 1;

  logic [`BRU_XLEN-1:0] r_regs [`BRU_PREG_NUM];
  logic [WR_NUM-1:0]    w_wr_en;

  // register 0 is never written, so it keeps the zero it got from reset
  always_comb begin
    for (int w = 0; w < WR_NUM; w++) begin
      w_wr_en[w] = i_wr[w].valid & (i_wr[w].tag != '0);
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < `BRU_PREG_NUM; i++) begin
        r_regs[i] <= '0;
      end
    end else begin
      for (int w = 0; w < WR_NUM; w++) begin
        if (w_wr_en[w]) begin
          r_regs[i_wr[w].tag] <= i_wr[w].data;
        end
      end
    end
  end

  generate
    for (genvar r = 0; r < 2; r++) begin : g_rd_port
      logic [WR_NUM-1:0]    w_bypass;
      logic [`BRU_XLEN-1:0] w_bypass_data;

      always_comb begin
        w_bypass_data = '0;
        for (int w = 0; w < WR_NUM; w++) begin
          w_bypass[w] = w_wr_en[w] & (i_wr[w].tag == i_rd_tag[r]);
          if (w_bypass[w]) begin
            w_bypass_data = w_bypass_data | i_wr[w].data;  // tags are distinct per cycle
          end
        end
      end

      assign o_rd_data[r] = (|w_bypass) ? w_bypass_data : r_regs[i_rd_tag[r]];
    end
  endgenerate

endmodule

`default_nettype wire

// File: hdl/bru_top.sv
`default_nettype none

`include "bru_params.svh"

module bru_top
  import bru_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  bru_issue_t               i_issue,
  input  logic [`BRU_RV_ENTRY-1:0] i_issue_index,
  input  bru_wr_t                  i_res_bus [`BRU_TGT_BUS],

  output bru_early_wr_t            o_early_wr,
  output bru_wr_t                  o_wb,
  output bru_upd_t                 o_br_upd,
  output bru_done_t                o_done
);

  logic [31:0]            w_ctrl_inst;
  bru_ctrl_t              w_ctrl;
  logic [`BRU_PREG_W-1:0] w_rd_tag  [2];
  logic [`BRU_XLEN-1:0]   w_rd_data [2];
  bru_wr_t                w_wb;
  bru_wr_t                w_rf_wr   [`BRU_TGT_BUS+1];

  // result buses take the low write ports, the link write the last one
  generate
    for (genvar b = 0; b < `BRU_TGT_BUS; b++) begin : g_rf_bus
      assign w_rf_wr[b] = i_res_bus[b];
    end
  endgenerate
  assign w_rf_wr[`BRU_TGT_BUS] = w_wb;
  assign o_wb = w_wb;

  bru_decoder u_decoder (
    .i_inst(w_ctrl_inst),
    .o_ctrl(w_ctrl)
  );

  bru_regfile u_regfile (
    .i_clk    (i_clk),
    .i_reset_n(i_reset_n),
    .i_rd_tag (w_rd_tag),
    .o_rd_data(w_rd_data),
    .i_wr     (w_rf_wr)
  );

  bru_pipe #(
    .RV_ENTRY(`BRU_RV_ENTRY)
  ) u_pipe (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_issue    (i_issue),
    .i_index    (i_issue_index),
    .o_ctrl_inst(w_ctrl_inst),
    .i_ctrl     (w_ctrl),
    .o_rd_tag   (w_rd_tag),
    .i_rd_data  (w_rd_data),
    .i_res_bus  (i_res_bus),
    .o_early_wr (o_early_wr),
    .o_wb       (w_wb),
    .o_br_upd   (o_br_upd),
    .o_done     (o_done)
  );

endmodule

`default_nettype wire

// File: include/bru_params.svh
`ifndef BRU_PARAMS_SVH
`define BRU_PARAMS_SVH

// data path and address width
`define BRU_XLEN 32

// physical register file size
`define BRU_PREG_NUM 64

// physical tag width, log2 of BRU_PREG_NUM
`define BRU_PREG_W 6

// external result buses that write the register file
`define BRU_TGT_BUS 2

// reservation station entries and width of the one-hot index
`define BRU_RV_ENTRY 8

`endif

// File: run_sim.sh
#!/bin/sh
# Builds the branch unit testbench with Verilator and runs it.
# A $fatal in the testbench gives a non-zero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  --top-module bru_tb \
  --Mdir obj_dir \
  -o bru_sim \
  -f bru_top.f

./obj_dir/bru_sim

// File: verification/bru_tb.sv
`default_nettype none

`include "bru_params.svh"

module bru_tb
  import bru_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_CYCLES  = 3000;
  localparam int BUS         = `BRU_TGT_BUS;
  localparam int WATCHDOG_NS = (NUM_CYCLES + 20) * 40;

  typedef logic [`BRU_PREG_W-1:0] tag_t;

  typedef struct packed {
    bru_done_t done;
    bru_upd_t  upd;
    bru_wr_t   wb;
  } outputs_t;

  logic                     clk;
  logic                     reset_n;
  bru_issue_t               issue;
  logic [`BRU_RV_ENTRY-1:0] issue_index;
  bru_wr_t                  res_bus [BUS];
  bru_early_wr_t            early_wr;
  bru_wr_t                  wb;
  bru_upd_t                 br_upd;
  bru_done_t                done;

  logic [31:0]              lfsr_state;
  logic [`BRU_XLEN-1:0]     m_regs [`BRU_PREG_NUM];  // mirror of the physical registers
  bru_issue_t               s1_issue;
  bru_issue_t               s2_issue;
  bru_issue_t               s3_issue;
  logic [2:0]               s1_kind;
  logic [2:0]               s2_kind;
  logic [`BRU_RV_ENTRY-1:0] s1_index;
  logic [`BRU_RV_ENTRY-1:0] s2_index;
  logic [`BRU_XLEN-1:0]     s2_rs1;
  logic [`BRU_XLEN-1:0]     s2_rs2;
  outputs_t                 cur_exp;  // what ex3 must show in the current cycle
  outputs_t                 exp_q [$];

  bru_top i_dut (
    .i_clk        (clk),
    .i_reset_n    (reset_n),
    .i_issue      (issue),
    .i_issue_index(issue_index),
    .i_res_bus    (res_bus),
    .o_early_wr   (early_wr),
    .o_wb         (wb),
    .o_br_upd     (br_upd),
    .o_done       (done)
  );

  always #20 clk = ~clk;

  function automatic logic lfsr_bit();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
      lfsr_state = lfsr_state ^ 32'h80200003;
    end
    return out_bit;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsr_bit()};
    end
    return value;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s expected 0x%08h got 0x%08h",
               $time, what, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "output check failed");
    end
  endtask

  function automatic logic writes_link(input bru_issue_t iss, input tag_t tag);
    return iss.valid & iss.rd_valid & (iss.rd_tag == tag);
  endfunction

  // link destinations still in the pipe, plus the one being issued
  function automatic logic tag_blocked(input tag_t tag, input bru_issue_t ex0);
    return writes_link(ex0, tag) | writes_link(s1_issue, tag) |
           writes_link(s2_issue, tag) | writes_link(s3_issue, tag);
  endfunction

  function automatic tag_t draw_src_tag();
    tag_t       tag;
    bru_issue_t none;
    none = '0;
    tag  = tag_t'(rand_bits(4));  // a narrow tag range makes registers get reused
    while (tag_blocked(tag, none)) begin
      tag = tag_t'(rand_bits(4));
    end
    return tag;
  endfunction

  function automatic tag_t choose_beat_tag(input tag_t prefer, input tag_t avoid,
                                           input bru_issue_t ex0);
    tag_t tag;
    tag = prefer;
    while (tag == '0 || tag == avoid || tag_blocked(tag, ex0)) begin
      tag = tag_t'(rand_bits(4));
    end
    return tag;
  endfunction

  task automatic build_issue(output bru_issue_t iss, output logic [2:0] kind,
                             output logic [`BRU_RV_ENTRY-1:0] index);
    logic [31:0] inst;
    inst = rand_bits(32);
    kind = 3'(rand_bits(3));  // 0 to 5 are the branches in funct3 order, 6 jal, 7 jalr
    case (kind)
      3'd6: inst[6:0] = 7'b1101111;
      3'd7: begin
        inst[6:0]   = 7'b1100111;
        inst[14:12] = 3'b000;
      end
      default: begin
        inst[6:0]   = 7'b1100011;
        inst[14:12] = (kind < 3'd2) ? kind : kind + 3'd2;
      end
    endcase
    iss           = '0;
    iss.valid     = (rand_bits(2) != 0);
    iss.pc        = rand_bits(30) << 2;
    iss.inst      = inst;
    iss.rs1_valid = (kind != 3'd6);
    iss.rs2_valid = (kind < 3'd6);
    iss.rd_valid  = (kind >= 3'd6);
    if (iss.rs1_valid) begin
      iss.rs1_tag        = draw_src_tag();
      iss.rs1_pred_ready = (rand_bits(2) == 0);
    end
    if (iss.rs2_valid) begin
      iss.rs2_tag        = draw_src_tag();
      iss.rs2_pred_ready = (rand_bits(2) == 0);
    end
    if (iss.rd_valid) begin
      iss.rd_tag = choose_beat_tag(tag_t'(rand_bits(4)), '0, '0);
    end
    iss.cmt_id = 8'(rand_bits(8));
    index      = `BRU_RV_ENTRY'(1) << rand_bits($clog2(`BRU_RV_ENTRY));
  endtask

  // beats often carry the sources of the ex1 and ex2 instructions
  task automatic drive_beats(input logic active, input bru_issue_t ex0);
    bru_wr_t beat;
    tag_t    prefer;
    tag_t    avoid;
    avoid = '0;
    for (int b = 0; b < BUS; b++) begin
      beat = '0;
      if (active) begin
        case (2'(rand_bits(2)))
          2'd0:    prefer = (b == 0) ? s2_issue.rs1_tag : s2_issue.rs2_tag;
          2'd1:    prefer = (b == 0) ? s1_issue.rs1_tag : s1_issue.rs2_tag;
          2'd2:    prefer = (b == 0) ? s2_issue.rs2_tag : s2_issue.rs1_tag;
          default: prefer = tag_t'(rand_bits(4));
        endcase
        beat.valid = (rand_bits(2) != 0);
        beat.tag   = choose_beat_tag(prefer, avoid, ex0);
        if (rand_bits(1) != 0) begin
          beat.data = rand_bits(2);  // small values make equal operands likely
        end else begin
          beat.data = rand_bits(32);
        end
        avoid = beat.tag;
      end
      res_bus[b] = beat;
    end
  endtask

  // ex1 read with write-through from this cycle's writers
  function automatic logic [31:0] read_operand(input tag_t tag);
    logic [31:0] value;
    value = m_regs[tag];
    for (int b = 0; b < BUS; b++) begin
      if (res_bus[b].valid && res_bus[b].tag == tag) begin
        value = res_bus[b].data;
      end
    end
    if (cur_exp.wb.valid && cur_exp.wb.tag == tag) begin
      value = cur_exp.wb.data;
    end
    if (tag == '0) begin
      value = '0;
    end
    return value;
  endfunction

  task automatic forward_operand(input tag_t tag, input logic src_valid,
                                 inout logic [31:0] data, output logic hit);
    hit = 1'b0;
    for (int b = 0; b < BUS; b++) begin
      if (src_valid && tag != '0 && res_bus[b].valid && res_bus[b].tag == tag) begin
        data = res_bus[b].data;
        hit  = 1'b1;
      end
    end
  endtask

  function automatic logic is_taken(input logic [2:0] kind, input logic [31:0] a,
                                    input logic [31:0] b);
    case (kind)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd2:    return $signed(a) < $signed(b);
      3'd3:    return $signed(a) >= $signed(b);
      3'd4:    return a < b;
      3'd5:    return a >= b;
      default: return 1'b1;
    endcase
  endfunction

  function automatic logic [31:0] jump_target(input logic [2:0] kind, input bru_issue_t iss,
                                              input logic [31:0] rs1);
    logic [31:0] i;
    i = iss.inst;
    case (kind)
      3'd6:    return iss.pc + {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
      3'd7:    return rs1 + {{20{i[31]}}, i[31:20]};
      default: return iss.pc + {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
    endcase
  endfunction

  task automatic step_model(input bru_issue_t ex0, input logic [2:0] kind,
                            input logic [`BRU_RV_ENTRY-1:0] index);
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic        hit1;
    logic        hit2;
    logic        pred_ok;
    outputs_t    nxt;
    rs1 = s2_rs1;
    rs2 = s2_rs2;
    forward_operand(s2_issue.rs1_tag, s2_issue.rs1_valid, rs1, hit1);
    forward_operand(s2_issue.rs2_tag, s2_issue.rs2_valid, rs2, hit2);
    pred_ok = (!s2_issue.rs1_pred_ready | hit1) & (!s2_issue.rs2_pred_ready | hit2);
    nxt             = '0;
    nxt.done.valid  = s2_issue.valid;
    nxt.done.replay = ~pred_ok;
    nxt.done.index  = s2_index;
    nxt.done.cmt_id = s2_issue.cmt_id;
    nxt.upd.valid   = s2_issue.valid & is_taken(s2_kind, rs1, rs2) & pred_ok;
    nxt.upd.target  = jump_target(s2_kind, s2_issue, rs1);
    nxt.upd.cmt_id  = s2_issue.cmt_id;
    nxt.wb.valid    = s2_issue.valid & (s2_kind >= 3'd6) & pred_ok;
    nxt.wb.tag      = s2_issue.rd_tag;
    nxt.wb.data     = s2_issue.pc + 32'd4;
    exp_q.push_back(nxt);
    s3_issue = s2_issue;
    s2_rs1   = read_operand(s1_issue.rs1_valid ? s1_issue.rs1_tag : '0);
    s2_rs2   = read_operand(s1_issue.rs2_valid ? s1_issue.rs2_tag : '0);
    s2_issue = s1_issue;
    s2_kind  = s1_kind;
    s2_index = s1_index;
    s1_issue = ex0;
    s1_kind  = kind;
    s1_index = index;
    for (int b = 0; b < BUS; b++) begin
      if (res_bus[b].valid && res_bus[b].tag != '0) begin
        m_regs[res_bus[b].tag] = res_bus[b].data;
      end
    end
    if (cur_exp.wb.valid && cur_exp.wb.tag != '0) begin
      m_regs[cur_exp.wb.tag] = cur_exp.wb.data;
    end
  endtask

  task automatic verify_outputs();
    logic early_valid;
    early_valid = s1_issue.valid & s1_issue.rd_valid;
    check_value(32'(early_wr.valid), 32'(early_valid), "o_early_wr.valid");
    if (early_valid) begin
      check_value(32'(early_wr.tag), 32'(s1_issue.rd_tag), "o_early_wr.tag");
    end
    check_value(32'(done.valid), 32'(cur_exp.done.valid), "o_done.valid");
    if (cur_exp.done.valid) begin
      check_value(32'(done.replay), 32'(cur_exp.done.replay), "o_done.replay");
      check_value(32'(done.index), 32'(cur_exp.done.index), "o_done.index");
      check_value(32'(done.cmt_id), 32'(cur_exp.done.cmt_id), "o_done.cmt_id");
    end
    check_value(32'(br_upd.valid), 32'(cur_exp.upd.valid), "o_br_upd.valid");
    if (cur_exp.upd.valid) begin
      check_value(br_upd.target, cur_exp.upd.target, "o_br_upd.target");
      check_value(32'(br_upd.cmt_id), 32'(cur_exp.upd.cmt_id), "o_br_upd.cmt_id");
    end
    check_value(32'(wb.valid), 32'(cur_exp.wb.valid), "o_wb.valid");
    if (cur_exp.wb.valid) begin
      check_value(32'(wb.tag), 32'(cur_exp.wb.tag), "o_wb.tag");
      check_value(wb.data, cur_exp.wb.data, "o_wb.data");
    end
  endtask

  task automatic confirm_idle(input string when);
    check_value(32'({early_wr.valid, wb.valid, br_upd.valid, done.valid}), 32'd0,
                {"valid outputs ", when});
  endtask

  initial begin
    bru_issue_t next_issue;
    logic [2:0] next_kind;
    logic [`BRU_RV_ENTRY-1:0] next_index;
    lfsr_state  = 32'ha3a9;
    clk         = 1'b0;
    reset_n     = 1'b0;
    issue       = '0;
    issue_index = '0;
    for (int b = 0; b < BUS; b++) begin
      res_bus[b] = '0;
    end
    for (int r = 0; r < `BRU_PREG_NUM; r++) begin
      m_regs[r] = '0;
    end
    s1_issue = '0;
    s2_issue = '0;
    s3_issue = '0;
    s1_kind  = '0;
    s2_kind  = '0;
    s1_index = '0;
    s2_index = '0;
    s2_rs1   = '0;
    s2_rs2   = '0;
    cur_exp  = '0;
    exp_q.push_back(cur_exp);  // ex3 holds zeros in the first cycle after reset
    repeat (5) @(posedge clk);
    #1;
    confirm_idle("during reset");
    repeat (5) @(posedge clk);
    #1;
    reset_n = 1'b1;
    confirm_idle("after reset");
    for (int cyc = 0; cyc < NUM_CYCLES + 4; cyc++) begin
      @(posedge clk);
      #1;
      cur_exp = exp_q.pop_front();
      verify_outputs();
      if (cyc < NUM_CYCLES) begin
        build_issue(next_issue, next_kind, next_index);
      end else begin
        next_issue = '0;  // drain the pipe
        next_kind  = '0;
        next_index = '0;
      end
      issue       = next_issue;
      issue_index = next_index;
      drive_beats(cyc < NUM_CYCLES, next_issue);
      step_model(next_issue, next_kind, next_index);
    end
    $display("Result: PASSED");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: simulation timed out after %0d ns without finishing", WATCHDOG_NS);
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire
